// File: bench/id_input.txt
# in:  stall valid pc inst | ex we waddr wdata | mem we waddr wdata | wb we waddr wdata | ex_is_load
# exp: rf_we rf_waddr alu_op data1 data2 mem_en mem_wen br_taken br_target stall_req_for_load
0 0 00000000 00000000 0 00 00000000 0 00 00000000 1 01 11111111 0 0 00 000 00000000 00000000 0 0 0 00000000 0
0 1 00400000 00000000 0 00 00000000 0 00 00000000 1 02 22222222 0 1 00 008 00000000 00000000 0 0 0 00000000 0
0 1 00400004 00222020 0 00 00000000 0 00 00000000 1 00 deadbeef 0 1 04 800 11111111 22222222 0 0 0 00000000 0
0 1 00400008 00012822 1 00 00000055 0 00 00000000 1 03 80000000 0 1 05 400 00000000 11111111 0 0 0 00000000 0
0 1 0040000c 00e13025 1 07 aaaa0001 1 07 aaaa0002 1 07 aaaa0003 0 1 06 020 aaaa0001 11111111 0 0 0 00000000 0
0 1 00400010 00e13025 0 07 aaaa0001 1 07 aaaa0002 1 07 aaaa0004 0 1 06 020 aaaa0002 11111111 0 0 0 00000000 0
0 1 00400014 00e13025 0 00 00000000 0 00 00000000 1 07 aaaa0005 0 1 06 020 aaaa0005 11111111 0 0 0 00000000 0
0 1 00400018 00e13026 0 00 00000000 0 00 00000000 1 10 16161616 0 1 06 010 aaaa0005 11111111 0 0 0 00000000 0
0 1 0040001c 0041402a 1 01 00000099 0 00 00000000 1 11 17171717 1 1 08 200 22222222 00000099 0 0 0 00000000 1
0 1 00400020 3c221234 1 01 00000099 0 00 00000000 0 00 00000000 1 1 02 001 00000099 22222222 0 0 0 00000000 0
0 1 00400024 08200040 1 01 00000099 0 00 00000000 0 00 00000000 1 0 00 000 00000099 00000000 0 0 1 00800100 0
0 1 00400028 0c000010 0 00 00000000 0 00 00000000 0 00 00000000 0 1 1f 800 00000000 00000000 0 0 1 00000040 0
06 1 00500000 0c000010 0 00 00000000 0 00 00000000 0 00 00000000 0 1 1f 800 00000000 00000000 0 0 1 00000040 0
02 1 00500004 0c000010 0 00 00000000 0 00 00000000 0 00 00000000 0 0 00 000 00000000 00000000 0 0 0 00000000 0
0 1 00400038 8c220008 0 00 00000000 0 00 00000000 0 00 00000000 0 1 02 800 11111111 22222222 1 0 0 00000000 0
0 1 0040003c ac220004 0 00 00000000 0 00 00000000 0 00 00000000 0 0 00 800 11111111 22222222 1 f 0 00000000 0
0 1 00400040 10210004 0 00 00000000 0 00 00000000 0 00 00000000 0 0 00 000 11111111 11111111 0 0 1 00400054 0
0 1 00400044 1421ffff 0 00 00000000 0 00 00000000 0 00 00000000 0 0 00 000 11111111 11111111 0 0 0 00400044 0
0 1 00400048 18000002 0 00 00000000 0 00 00000000 0 00 00000000 0 0 00 000 00000000 00000000 0 0 1 00400054 0
0 1 0040004c 1c600001 0 00 00000000 0 00 00000000 0 00 00000000 0 0 00 000 80000000 00000000 0 0 0 00400054 0
0 1 00400050 04600003 0 00 00000000 0 00 00000000 0 00 00000000 0 0 00 000 80000000 00000000 0 0 1 00400060 0
0 1 00400054 04610003 0 00 00000000 0 00 00000000 0 00 00000000 0 0 00 000 80000000 11111111 0 0 0 00400064 0
0 1 00400058 04300002 0 00 00000000 0 00 00000000 0 00 00000000 0 1 1f 800 11111111 16161616 0 0 0 00400064 0
0 1 0040005c 04310002 0 00 00000000 0 00 00000000 0 00 00000000 0 1 1f 800 11111111 17171717 0 0 1 00400068 0
0 1 00400060 00400008 0 00 00000000 0 00 00000000 0 00 00000000 0 0 00 000 22222222 00000000 0 0 1 22222222 0
0 1 00400064 00205809 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0b 800 11111111 00000000 0 0 1 11111111 0
0 1 00400068 28220005 0 00 00000000 0 00 00000000 0 00 00000000 0 1 02 200 11111111 22222222 0 0 0 00000000 0
0 1 0040006c 00016100 0 00 00000000 0 00 00000000 0 00 00000000 0 1 0c 008 00000000 11111111 0 0 0 00000000 0
0 1 00400070 342200ff 0 00 00000000 0 00 00000000 0 00 00000000 0 1 02 020 11111111 22222222 0 0 0 00000000 0

// File: bench/tb_id_stage.sv
module tb_id_stage;

    localparam int nfields = 24;            // fields per vector line

    logic              clk;
    logic              rst;
    id_pkg::stall_t    stall;
    id_pkg::if_to_id_t if_to_id;
    id_pkg::word_t     inst_sram_rdata;
    id_pkg::rf_write_t ex_fwd;
    logic              ex_is_load;
    id_pkg::rf_write_t mem_fwd;
    id_pkg::rf_write_t wb_write;
    id_pkg::id_to_ex_t id_to_ex;
    id_pkg::branch_t   br;
    logic              stall_req_for_load;

    logic [31:0]       fields [$];          // nfields words per vector
    id_pkg::if_to_id_t exp_if_id;           // what IF/ID should hold
    int                nvec;
    int                errors;
    int                cycles;
    int                limit;

    id_stage DUT (
        .clk                (clk),
        .rst                (rst),
        .stall              (stall),
        .if_to_id           (if_to_id),
        .inst_sram_rdata    (inst_sram_rdata),
        .ex_fwd             (ex_fwd),
        .ex_is_load         (ex_is_load),
        .mem_fwd            (mem_fwd),
        .wb_write           (wb_write),
        .id_to_ex           (id_to_ex),
        .br                 (br),
        .stall_req_for_load (stall_req_for_load)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit grows with the vector count
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] field(input int k, input int i);
        return fields[k * nfields + i];
    endfunction

    task automatic read_vectors();
        int          fd;
        int          r;
        string       line;
        logic [31:0] f [nfields];
        fd = $fopen("bench/id_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file bench/id_input.txt");
            errors = errors + 1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (r == 0 || line.len() < 10 || line[0] == 8'h23) begin
                continue;                       // blank or comment line
            end
            r = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                        f[21], f[22], f[23]);
            if (r != nfields) begin
                $display("badly formed vector line: %s", line);
                errors = errors + 1;
                continue;
            end
            for (int i = 0; i < nfields; i++) begin
                fields.push_back(f[i]);
            end
        end
        $fclose(fd);
    endtask

    // fetch side runs one cycle ahead of its inst
    task automatic drive_fetch(input int k);
        stall          = 6'(field(k, 0));
        if_to_id.valid = 1'(field(k, 1));
        if_to_id.pc    = field(k, 2);
    endtask

    task automatic drive_decode(input int k);
        inst_sram_rdata = field(k, 3);
        ex_fwd.we       = 1'(field(k, 4));
        ex_fwd.waddr    = 5'(field(k, 5));
        ex_fwd.wdata    = field(k, 6);
        mem_fwd.we      = 1'(field(k, 7));
        mem_fwd.waddr   = 5'(field(k, 8));
        mem_fwd.wdata   = field(k, 9);
        wb_write.we     = 1'(field(k, 10));
        wb_write.waddr  = 5'(field(k, 11));
        wb_write.wdata  = field(k, 12);
        ex_is_load      = 1'(field(k, 13));
    endtask

    // IF/ID contents after an edge, by the stall bus rule
    task automatic track_if_id();
        case ({stall[2], stall[1]})
            2'b01:   exp_if_id = '0;            // bubble
            2'b11:   exp_if_id = exp_if_id;     // hold
            default: exp_if_id = if_to_id;
        endcase
    endtask

    // ALU source selectors called for by each instruction class
    task automatic expected_sources(input logic valid, input logic [31:0] inst,
                                    output id_pkg::alu_src1_t s1,
                                    output id_pkg::alu_src2_t s2);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rt;
        op = inst[31:26];
        fn = inst[5:0];
        rt = inst[20:16];
        s1 = '0;
        s2 = '0;
        if (!valid) begin
            return;
        end
        if ((op == id_pkg::op_special && fn == id_pkg::fn_jalr) || op == id_pkg::op_jal
                || (op == id_pkg::op_regimm
                    && (rt == id_pkg::rt_bltzal || rt == id_pkg::rt_bgezal))) begin
            s1.pc     = 1'b1;                   // pc + 8 into the link register
            s2.const8 = 1'b1;
        end else if (op == id_pkg::op_special) begin
            s1.sa = fn inside {id_pkg::fn_sll, id_pkg::fn_srl, id_pkg::fn_sra};
            s1.rs = fn inside {id_pkg::fn_add, id_pkg::fn_addu, id_pkg::fn_sub,
                               id_pkg::fn_subu, id_pkg::fn_and, id_pkg::fn_or,
                               id_pkg::fn_xor, id_pkg::fn_nor, id_pkg::fn_slt,
                               id_pkg::fn_sltu, id_pkg::fn_sllv, id_pkg::fn_srlv,
                               id_pkg::fn_srav};
            s2.rt = s1.sa || s1.rs;
        end else if (op inside {id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti,
                                id_pkg::op_sltiu, id_pkg::op_lw, id_pkg::op_sw}) begin
            s1.rs       = 1'b1;
            s2.imm_sign = 1'b1;
        end else if (op inside {id_pkg::op_andi, id_pkg::op_ori, id_pkg::op_xori}) begin
            s1.rs       = 1'b1;
            s2.imm_zero = 1'b1;
        end else if (op == id_pkg::op_lui) begin
            s2.imm_sign = 1'b1;                 // rs unused
        end
    endtask

    task automatic compare(input string name, input int k, input logic [31:0] got,
                           input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH vector %0d %s: got %h expected %h", k, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_outputs(input int k);
        logic [31:0]       inst;
        id_pkg::alu_src1_t src1;
        id_pkg::alu_src2_t src2;
        inst = field(k, 3);
        expected_sources(exp_if_id.valid, inst, src1, src2);
        compare("pc", k, id_to_ex.pc, exp_if_id.pc);
        compare("inst", k, id_to_ex.inst, inst);
        compare("rf_we", k, 32'(id_to_ex.rf_we), field(k, 14));
        compare("rf_waddr", k, 32'(id_to_ex.rf_waddr), field(k, 15));
        compare("alu_op", k, 32'(id_to_ex.alu_op), field(k, 16));
        compare("alu_src1", k, 32'(id_to_ex.alu_src1), 32'(src1));
        compare("alu_src2", k, 32'(id_to_ex.alu_src2), 32'(src2));
        compare("rf_res_mem", k, 32'(id_to_ex.rf_res_mem),
                32'(exp_if_id.valid && inst[31:26] == id_pkg::op_lw));
        compare("data1", k, id_to_ex.data1, field(k, 17));
        compare("data2", k, id_to_ex.data2, field(k, 18));
        compare("mem_en", k, 32'(id_to_ex.mem_en), field(k, 19));
        compare("mem_wen", k, 32'(id_to_ex.mem_wen), field(k, 20));
        compare("br.taken", k, 32'(br.taken), field(k, 21));
        compare("br.target", k, br.target, field(k, 22));
        compare("stall_req_for_load", k, 32'(stall_req_for_load), field(k, 23));
    endtask

    initial begin
        rst             = 1'b1;
        stall           = '0;
        if_to_id        = '0;
        inst_sram_rdata = '0;
        ex_fwd          = '0;
        ex_is_load      = 1'b0;
        mem_fwd         = '0;
        wb_write        = '0;
        exp_if_id       = '0;
        errors          = 0;
        cycles          = 0;
        limit           = 0;
        read_vectors();
        nvec  = fields.size() / nfields;
        limit = nvec * 2 + 20;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        if (nvec > 0) begin
            drive_fetch(0);
        end
        for (int k = 0; k < nvec; k++) begin
            @(posedge clk);
            #1;
            track_if_id();
            drive_decode(k);
            if (k + 1 < nvec) begin
                drive_fetch(k + 1);
            end else begin
                stall    = '0;
                if_to_id = '0;                  // fetch goes idle
            end
            #6;                                 // just before the next edge
            check_outputs(k);
        end
        if (nvec == 0) begin
            $display("no vectors were read");
            errors = errors + 1;
        end
        @(posedge clk);
        $display("vectors: %0d, errors: %0d", nvec, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: design/branch_unit.sv
module branch_unit (
    input  id_pkg::br_kind_t br_kind,
    input  id_pkg::word_t    pc,
    input  id_pkg::word_t    inst,
    input  id_pkg::word_t    data1,
    input  id_pkg::word_t    data2,
    output id_pkg::branch_t  br
);

    id_pkg::word_t cond_target;
    id_pkg::word_t region_target;
    logic          rs_neg;
    logic          rs_zero;

    assign cond_target   = pc + 32'd4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    assign region_target = {pc[31:28], inst[25:0], 2'b00};   // 256 MB region

    // signed compares against zero reduce to sign bit and zero test
    assign rs_neg  = data1[31];
    assign rs_zero = (data1 == '0);

    always_comb begin
        br.taken  = 1'b0;
        br.target = cond_target;
        case (br_kind)
            id_pkg::br_jump_imm: begin
                br.taken  = 1'b1;
                br.target = region_target;
            end
            id_pkg::br_jump_reg: begin
                br.taken  = 1'b1;
                br.target = data1;
            end
            id_pkg::br_eq:  br.taken = (data1 == data2);
            id_pkg::br_ne:  br.taken = (data1 != data2);
            id_pkg::br_lez: br.taken = rs_neg || rs_zero;
            id_pkg::br_gtz: br.taken = !rs_neg && !rs_zero;
            id_pkg::br_ltz: br.taken = rs_neg;
            id_pkg::br_gez: br.taken = !rs_neg;
            default: begin
                br.taken  = 1'b0;
                br.target = '0;                     // no branch
            end
        endcase
    end

endmodule

// File: design/id_pkg.sv
package id_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [data_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [5:0]            stall_t;     // bit 1 id stop, bit 2 ex stop

    localparam reg_addr_t link_reg = 5'd31;     // return address for jal and friends

    typedef struct packed {
        logic  valid;                           // fetch enable
        word_t pc;
    } if_to_id_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_slt;
        logic op_sltu;
        logic op_and;
        logic op_nor;
        logic op_or;
        logic op_xor;
        logic op_sll;
        logic op_srl;
        logic op_sra;
        logic op_lui;
    } alu_op_t;

    typedef struct packed {
        logic sa;
        logic pc;
        logic rs;
    } alu_src1_t;

    typedef struct packed {
        logic imm_zero;
        logic const8;                           // pc + 8 for link forms
        logic imm_sign;
        logic rt;
    } alu_src2_t;

    typedef struct packed {
        logic link;
        logic rt;
        logic rd;
    } rf_dst_t;

    typedef enum logic [3:0] {
        br_none,
        br_jump_imm,
        br_jump_reg,
        br_eq,
        br_ne,
        br_lez,
        br_gtz,
        br_ltz,
        br_gez
    } br_kind_t;

    typedef struct packed {
        alu_op_t    alu_op;
        alu_src1_t  alu_src1;
        alu_src2_t  alu_src2;
        logic       mem_en;
        logic [3:0] mem_wen;
        logic       rf_we;
        rf_dst_t    rf_dst;
        logic       rf_res_mem;                 // write-back takes load data
        logic       use_rs;
        logic       use_rt;
        br_kind_t   br_kind;
    } decode_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

    typedef struct packed {
        word_t      pc;
        word_t      inst;
        alu_op_t    alu_op;
        alu_src1_t  alu_src1;
        alu_src2_t  alu_src2;
        logic       mem_en;
        logic [3:0] mem_wen;
        logic       rf_we;
        reg_addr_t  rf_waddr;
        logic       rf_res_mem;
        word_t      data1;
        word_t      data2;
    } id_to_ex_t;

    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_regimm  = 6'b000001;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;
    localparam logic [5:0] op_addi    = 6'b001000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_sltiu   = 6'b001011;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;

    localparam logic [5:0] fn_sll     = 6'b000000;
    localparam logic [5:0] fn_srl     = 6'b000010;
    localparam logic [5:0] fn_sra     = 6'b000011;
    localparam logic [5:0] fn_sllv    = 6'b000100;
    localparam logic [5:0] fn_srlv    = 6'b000110;
    localparam logic [5:0] fn_srav    = 6'b000111;
    localparam logic [5:0] fn_jr      = 6'b001000;
    localparam logic [5:0] fn_jalr    = 6'b001001;
    localparam logic [5:0] fn_add     = 6'b100000;
    localparam logic [5:0] fn_addu    = 6'b100001;
    localparam logic [5:0] fn_sub     = 6'b100010;
    localparam logic [5:0] fn_subu    = 6'b100011;
    localparam logic [5:0] fn_and     = 6'b100100;
    localparam logic [5:0] fn_or      = 6'b100101;
    localparam logic [5:0] fn_xor     = 6'b100110;
    localparam logic [5:0] fn_nor     = 6'b100111;
    localparam logic [5:0] fn_slt     = 6'b101010;
    localparam logic [5:0] fn_sltu    = 6'b101011;

    // regimm forms are told apart by the rt field
    localparam reg_addr_t rt_bltz     = 5'b00000;
    localparam reg_addr_t rt_bgez     = 5'b00001;
    localparam reg_addr_t rt_bltzal   = 5'b10000;
    localparam reg_addr_t rt_bgezal   = 5'b10001;

endpackage

// File: design/id_stage.sv
module id_stage (
    input  logic              clk,
    input  logic              rst,
    input  id_pkg::stall_t    stall,
    input  id_pkg::if_to_id_t if_to_id,
    input  id_pkg::word_t     inst_sram_rdata,
    input  id_pkg::rf_write_t ex_fwd,
    input  logic              ex_is_load,
    input  id_pkg::rf_write_t mem_fwd,
    input  id_pkg::rf_write_t wb_write,
    output id_pkg::id_to_ex_t id_to_ex,
    output id_pkg::branch_t   br,
    output logic              stall_req_for_load
);

    id_pkg::if_to_id_t if_id_r;
    id_pkg::reg_addr_t rs;
    id_pkg::reg_addr_t rt;
    id_pkg::reg_addr_t rd;
    id_pkg::word_t     rf_rdata1;
    id_pkg::word_t     rf_rdata2;
    id_pkg::word_t     data1;
    id_pkg::word_t     data2;
    id_pkg::decode_t   dec;
    id_pkg::reg_addr_t rf_waddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_r <= '0;
        end else if (stall[1] && !stall[2]) begin
            if_id_r <= '0;                          // bubble into ex
        end else if (!stall[1]) begin
            if_id_r <= if_to_id;
        end
    end

    // inst arrives one cycle after its pc, so it lines up with if_id_r
    assign rs = inst_sram_rdata[25:21];
    assign rt = inst_sram_rdata[20:16];
    assign rd = inst_sram_rdata[15:11];

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_write)
    );

    inst_decoder u_inst_decoder (
        .inst  (inst_sram_rdata),
        .valid (if_id_r.valid),
        .dec   (dec)
    );

    operand_forward u_operand_forward (
        .rs                 (rs),
        .rt                 (rt),
        .rf_rdata1          (rf_rdata1),
        .rf_rdata2          (rf_rdata2),
        .ex_fwd             (ex_fwd),
        .mem_fwd            (mem_fwd),
        .wb_fwd             (wb_write),
        .ex_is_load         (ex_is_load),
        .use_rs             (dec.use_rs),
        .use_rt             (dec.use_rt),
        .valid              (if_id_r.valid),
        .data1              (data1),
        .data2              (data2),
        .stall_req_for_load (stall_req_for_load)
    );

    branch_unit u_branch_unit (
        .br_kind (dec.br_kind),
        .pc      (if_id_r.pc),
        .inst    (inst_sram_rdata),
        .data1   (data1),
        .data2   (data2),
        .br      (br)
    );

    // one-hot dst select
    assign rf_waddr = ({5{dec.rf_dst.rd}}   & rd)
                    | ({5{dec.rf_dst.rt}}   & rt)
                    | ({5{dec.rf_dst.link}} & id_pkg::link_reg);

    always_comb begin
        id_to_ex.pc         = if_id_r.pc;
        id_to_ex.inst       = inst_sram_rdata;
        id_to_ex.alu_op     = dec.alu_op;
        id_to_ex.alu_src1   = dec.alu_src1;
        id_to_ex.alu_src2   = dec.alu_src2;
        id_to_ex.mem_en     = dec.mem_en;
        id_to_ex.mem_wen    = dec.mem_wen;
        id_to_ex.rf_we      = dec.rf_we;
        id_to_ex.rf_waddr   = rf_waddr;
        id_to_ex.rf_res_mem = dec.rf_res_mem;
        id_to_ex.data1      = data1;
        id_to_ex.data2      = data2;            // also store data for sw
    end

endmodule

// File: design/inst_decoder.sv
module inst_decoder (
    input  id_pkg::word_t   inst,
    input  logic            valid,
    output id_pkg::decode_t dec
);

    localparam id_pkg::alu_op_t alu_add  = '{op_add:  1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_sub  = '{op_sub:  1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_slt  = '{op_slt:  1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_sltu = '{op_sltu: 1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_and  = '{op_and:  1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_nor  = '{op_nor:  1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_or   = '{op_or:   1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_xor  = '{op_xor:  1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_sll  = '{op_sll:  1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_srl  = '{op_srl:  1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_sra  = '{op_sra:  1'b1, default: 1'b0};
    localparam id_pkg::alu_op_t alu_lui  = '{op_lui:  1'b1, default: 1'b0};

    logic [5:0]        opcode;
    logic [5:0]        funct;
    id_pkg::reg_addr_t rt;
    id_pkg::decode_t   raw;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign rt     = inst[20:16];

    // rd <- rs op rt, or rd <- rt shifted by sa
    function automatic id_pkg::decode_t alu_reg(input id_pkg::alu_op_t op, input logic by_sa);
        id_pkg::decode_t d;
        d              = '0;
        d.alu_op       = op;
        d.alu_src1.rs  = !by_sa;
        d.alu_src1.sa  = by_sa;
        d.alu_src2.rt  = 1'b1;
        d.rf_we        = 1'b1;
        d.rf_dst.rd    = 1'b1;
        d.use_rs       = !by_sa;
        d.use_rt       = 1'b1;
        return d;
    endfunction

    // rt <- rs op imm
    function automatic id_pkg::decode_t alu_imm(input id_pkg::alu_op_t op, input logic zero_ext);
        id_pkg::decode_t d;
        d                   = '0;
        d.alu_op            = op;
        d.alu_src1.rs       = 1'b1;
        d.alu_src2.imm_sign = !zero_ext;
        d.alu_src2.imm_zero = zero_ext;
        d.rf_we             = 1'b1;
        d.rf_dst.rt         = 1'b1;
        d.use_rs            = 1'b1;
        return d;
    endfunction

    // link forms write pc + 8
    function automatic id_pkg::decode_t link(input id_pkg::br_kind_t kind, input logic to_rd);
        id_pkg::decode_t d;
        d                 = '0;
        d.alu_op          = alu_add;
        d.alu_src1.pc     = 1'b1;
        d.alu_src2.const8 = 1'b1;
        d.rf_we           = 1'b1;
        d.rf_dst.rd       = to_rd;
        d.rf_dst.link     = !to_rd;
        d.use_rs          = (kind != id_pkg::br_jump_imm);
        d.br_kind         = kind;
        return d;
    endfunction

    function automatic id_pkg::decode_t branch(input id_pkg::br_kind_t kind, input logic cmp_rt);
        id_pkg::decode_t d;
        d         = '0;
        d.use_rs  = 1'b1;
        d.use_rt  = cmp_rt;
        d.br_kind = kind;
        return d;
    endfunction

    always_comb begin
        raw = '0;                                   // undefined encodings do nothing
        case (opcode)
            id_pkg::op_special: begin
                case (funct)
                    id_pkg::fn_add, id_pkg::fn_addu: raw = alu_reg(alu_add, 1'b0);
                    id_pkg::fn_sub, id_pkg::fn_subu: raw = alu_reg(alu_sub, 1'b0);
                    id_pkg::fn_slt:  raw = alu_reg(alu_slt, 1'b0);
                    id_pkg::fn_sltu: raw = alu_reg(alu_sltu, 1'b0);
                    id_pkg::fn_and:  raw = alu_reg(alu_and, 1'b0);
                    id_pkg::fn_or:   raw = alu_reg(alu_or, 1'b0);
                    id_pkg::fn_xor:  raw = alu_reg(alu_xor, 1'b0);
                    id_pkg::fn_nor:  raw = alu_reg(alu_nor, 1'b0);
                    id_pkg::fn_sll:  raw = alu_reg(alu_sll, 1'b1);
                    id_pkg::fn_srl:  raw = alu_reg(alu_srl, 1'b1);
                    id_pkg::fn_sra:  raw = alu_reg(alu_sra, 1'b1);
                    id_pkg::fn_sllv: raw = alu_reg(alu_sll, 1'b0);
                    id_pkg::fn_srlv: raw = alu_reg(alu_srl, 1'b0);
                    id_pkg::fn_srav: raw = alu_reg(alu_sra, 1'b0);
                    id_pkg::fn_jr:   raw = branch(id_pkg::br_jump_reg, 1'b0);
                    id_pkg::fn_jalr: raw = link(id_pkg::br_jump_reg, 1'b1);
                    default: raw = '0;
                endcase
            end
            id_pkg::op_regimm: begin
                case (rt)
                    id_pkg::rt_bltz:   raw = branch(id_pkg::br_ltz, 1'b0);
                    id_pkg::rt_bgez:   raw = branch(id_pkg::br_gez, 1'b0);
                    id_pkg::rt_bltzal: raw = link(id_pkg::br_ltz, 1'b0);
                    id_pkg::rt_bgezal: raw = link(id_pkg::br_gez, 1'b0);
                    default: raw = '0;
                endcase
            end
            id_pkg::op_j:     raw.br_kind = id_pkg::br_jump_imm;
            id_pkg::op_jal:   raw = link(id_pkg::br_jump_imm, 1'b0);
            id_pkg::op_beq:   raw = branch(id_pkg::br_eq, 1'b1);
            id_pkg::op_bne:   raw = branch(id_pkg::br_ne, 1'b1);
            id_pkg::op_blez:  raw = branch(id_pkg::br_lez, 1'b0);
            id_pkg::op_bgtz:  raw = branch(id_pkg::br_gtz, 1'b0);
            id_pkg::op_addi, id_pkg::op_addiu: raw = alu_imm(alu_add, 1'b0);
            id_pkg::op_slti:  raw = alu_imm(alu_slt, 1'b0);
            id_pkg::op_sltiu: raw = alu_imm(alu_sltu, 1'b0);
            id_pkg::op_andi:  raw = alu_imm(alu_and, 1'b1);
            id_pkg::op_ori:   raw = alu_imm(alu_or, 1'b1);
            id_pkg::op_xori:  raw = alu_imm(alu_xor, 1'b1);
            id_pkg::op_lui: begin
                raw             = alu_imm(alu_lui, 1'b0);
                raw.alu_src1.rs = 1'b0;             // lui ignores rs
                raw.use_rs      = 1'b0;
            end
            id_pkg::op_lw: begin
                raw            = alu_imm(alu_add, 1'b0);
                raw.mem_en     = 1'b1;
                raw.rf_res_mem = 1'b1;
            end
            id_pkg::op_sw: begin
                raw         = alu_imm(alu_add, 1'b0);   // address = rs + imm
                raw.rf_we   = 1'b0;
                raw.rf_dst  = '0;
                raw.mem_en  = 1'b1;
                raw.mem_wen = 4'b1111;
                raw.use_rt  = 1'b1;                 // store data
            end
            default: raw = '0;
        endcase
    end

    assign dec = valid ? raw : '0;                  // bubble or idle fetch

endmodule

// File: design/operand_forward.sv
module operand_forward (
    input  id_pkg::reg_addr_t rs,
    input  id_pkg::reg_addr_t rt,
    input  id_pkg::word_t     rf_rdata1,
    input  id_pkg::word_t     rf_rdata2,
    input  id_pkg::rf_write_t ex_fwd,
    input  id_pkg::rf_write_t mem_fwd,
    input  id_pkg::rf_write_t wb_fwd,
    input  logic              ex_is_load,
    input  logic              use_rs,
    input  logic              use_rt,
    input  logic              valid,
    output id_pkg::word_t     data1,
    output id_pkg::word_t     data2,
    output logic              stall_req_for_load
);

    logic load_hits_rs;
    logic load_hits_rt;

    // a pending write only counts when enabled and not aimed at $0
    function automatic logic hits(input id_pkg::rf_write_t w, input id_pkg::reg_addr_t addr);
        return w.we && w.waddr != '0 && w.waddr == addr;
    endfunction

    // newest value wins: ex, then mem, then wb, then the array
    function automatic id_pkg::word_t resolve(
        input id_pkg::reg_addr_t addr,
        input id_pkg::word_t     rf_data,
        input id_pkg::rf_write_t ex_w,
        input id_pkg::rf_write_t mem_w,
        input id_pkg::rf_write_t wb_w
    );
        if (hits(ex_w, addr)) begin
            return ex_w.wdata;
        end else if (hits(mem_w, addr)) begin
            return mem_w.wdata;
        end else if (hits(wb_w, addr)) begin
            return wb_w.wdata;                      // same-cycle regfile write
        end
        return rf_data;
    endfunction

    assign data1 = resolve(rs, rf_rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign data2 = resolve(rt, rf_rdata2, ex_fwd, mem_fwd, wb_fwd);

    // load result not ready until mem, so ex forwarding cannot cover it
    assign load_hits_rs = use_rs && hits(ex_fwd, rs);
    assign load_hits_rt = use_rt && hits(ex_fwd, rt);

    assign stall_req_for_load = valid && ex_is_load && (load_hits_rs || load_hits_rt);

endmodule

// File: design/regfile.sv
module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    input  id_pkg::rf_write_t wr
);

    id_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;             // $0 stays untouched
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the ID stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_id_stage -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_id_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

// File: vlog.f
design/id_pkg.sv
design/regfile.sv
design/operand_forward.sv
design/inst_decoder.sv
design/branch_unit.sv
design/id_stage.sv
bench/tb_id_stage.sv
